// ==== common/obj_pkg.sv ====
`default_nettype none

// shared constants and types of the sprite layer.
package obj_pkg;

    localparam int NUM_OBJ   = 64;                  // entries in the sprite attribute table.
    localparam int OBJ_WORDS = 4;                   // 16-bit words per table entry.
    localparam int IDX_W     = $clog2(NUM_OBJ);     // width of the entry index.
    localparam int WSEL_W    = $clog2(OBJ_WORDS);   // width of the word select.

    localparam int HPOS_W    = 9;                   // horizontal position width.
    localparam int VPOS_W    = 9;                   // vertical line number width.
    localparam int LB_DEPTH  = 1 << HPOS_W;         // entries per line-buffer bank.
    localparam int ROW_PIX   = 8;                   // pixels in one pattern row.

    // bit positions inside the table entry words.
    localparam int W0_EN     = 15;                  // word 0, entry enable.
    localparam int W0_SIZE   = 8;                   // word 0, set for 16x16.
    localparam int W1_HFLIP  = 14;                  // word 1, horizontal mirror.
    localparam int W1_VFLIP  = 15;                  // word 1, vertical mirror.

    typedef logic [HPOS_W-1:0]       hpos_t;        // hdump, sprite x and buffer address.
    typedef logic [VPOS_W-1:0]       vpos_t;        // vrender.
    typedef logic [IDX_W+WSEL_W-1:0] ram_addr_t;    // entry index on top, word below.
    typedef logic [15:0]             ram_word_t;
    typedef logic [11:0]             obj_code_t;
    typedef logic [3:0]              ysub_t;        // row inside the sprite.
    typedef logic [3:0]              pal_t;
    typedef logic [1:0]              prio_t;
    typedef logic [3:0]              col_t;         // colour index, zero is transparent.

    // rom word address is {code, half, ysub}.
    typedef logic [$bits(obj_code_t)+$bits(ysub_t):0] rom_addr_t;

    // one row of 8 pixels, leftmost pixel in the top nibble.
    typedef logic [ROW_PIX*$bits(col_t)-1:0] rom_word_t;

    // layer pixel as {prio, pal, colour}.
    typedef logic [$bits(prio_t)+$bits(pal_t)+$bits(col_t)-1:0] obj_pxl_t;

    // scan controller states.
    typedef enum logic [2:0] {
        S_IDLE,     // nothing to do until the next line strobe.
        S_READ,     // four table words are addressed back to back.
        S_CHECK,    // last word arrives, vertical hit is decided.
        S_ISSUE,    // draw strobe is out this clock.
        S_WAIT      // the draw engine is still busy.
    } scan_state_t;

endpackage

`default_nettype wire

// ==== obj/obj_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_scan (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 hs,
    input  wire                 lvbl,
    input  wire obj_pkg::vpos_t vrender,

    output obj_pkg::ram_addr_t  ram_addr,
    input  wire obj_pkg::ram_word_t ram_dout,

    output logic                draw,
    input  wire                 busy,
    output obj_pkg::obj_code_t  code,
    output obj_pkg::ysub_t      ysub,
    output obj_pkg::hpos_t      xpos,
    output logic                hflip,
    output logic                size,
    output obj_pkg::pal_t       pal,
    output obj_pkg::prio_t      prio
);
    import obj_pkg::*;

    scan_state_t        state;
    logic [IDX_W-1:0]   idx;            // entry being visited.
    logic [WSEL_W-1:0]  wsel;           // word being addressed.
    ram_word_t          word_q [OBJ_WORDS];
    vpos_t              line_q;         // line that is being prepared.
    ysub_t              ysub_q;

    logic [7:0]         diff;           // distance from the sprite top, modulo 256.
    logic [4:0]         height;
    logic [4:0]         hmax;
    logic               hit;
    logic               last;
    ysub_t              row;

    // the RAM answers one clock after the address, so the word select runs one step ahead.
    assign ram_addr = {idx, wsel};

    assign height = word_q[0][W0_SIZE] ? 5'd16 : 5'd8;
    assign hmax   = height - 5'd1;
    assign diff   = line_q[7:0] - word_q[0][7:0];
    assign hit    = word_q[0][W0_EN] && (diff < {3'b000, height});
    // a mirrored sprite counts its rows up from the bottom edge.
    assign row    = word_q[1][W1_VFLIP] ? hmax[3:0] - diff[3:0] : diff[3:0];
    assign last   = idx == IDX_W'(NUM_OBJ - 1);

    // the request fields come straight from the holding registers.
    assign code  = word_q[1][11:0];
    assign hflip = word_q[1][W1_HFLIP];
    assign size  = word_q[0][W0_SIZE];
    assign xpos  = word_q[2][8:0];
    assign pal   = word_q[3][3:0];
    assign prio  = word_q[3][5:4];
    assign ysub  = ysub_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            idx   <= '0;
            wsel  <= '0;
            draw  <= 1'b0;
        end else if (hs) begin
            // a new line aborts whatever is left of the old scan.
            draw  <= 1'b0;
            idx   <= '0;
            wsel  <= '0;
            state <= lvbl ? S_READ : S_IDLE;
        end else begin
            draw <= 1'b0;   // the strobe lasts a single clock.
            case (state)
                S_READ: begin
                    wsel <= wsel + 1'b1;   // wraps back to word 0 for the next entry.
                    if (wsel == WSEL_W'(OBJ_WORDS - 1)) begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (hit) begin
                        draw  <= 1'b1;
                        state <= S_ISSUE;
                    end else if (last) begin
                        state <= S_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= S_READ;
                    end
                end
                // busy only shows up after this clock, so it is not looked at here.
                S_ISSUE: state <= S_WAIT;
                S_WAIT: begin
                    if (!busy) begin
                        if (last) begin
                            state <= S_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= S_READ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hs) begin
            line_q <= vrender + 1'b1;     // sprites are gathered for the next line.
        end
        // word n shows up while word n+1 is addressed.
        if (state == S_READ && wsel != '0) begin
            word_q[wsel - 1'b1] <= ram_dout;
        end
        if (state == S_CHECK) begin
            word_q[OBJ_WORDS-1] <= ram_dout;   // attributes word arrives last.
            ysub_q              <= row;
        end
    end

endmodule

`default_nettype wire

// ==== obj/obj_draw.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_draw (
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire                     draw,
    output logic                    busy,
    input  wire obj_pkg::obj_code_t code,
    input  wire obj_pkg::ysub_t     ysub,
    input  wire obj_pkg::hpos_t     xpos,
    input  wire                     hflip,
    input  wire                     size,
    input  wire obj_pkg::pal_t      pal,
    input  wire obj_pkg::prio_t     prio,

    output logic                    rom_cs,
    output obj_pkg::rom_addr_t      rom_addr,
    input  wire                     rom_ok,
    input  wire obj_pkg::rom_word_t rom_data,

    output logic                    wr_en,
    output obj_pkg::hpos_t          wr_addr,
    output obj_pkg::obj_pxl_t       wr_pxl
);
    import obj_pkg::*;

    logic       emit_q;         // pixels of the fetched row are being written.
    logic       more_q;         // a second half is still to be fetched.
    logic       half_q;         // pattern half that is fetched.
    logic [2:0] cnt_q;          // pixel within the row, in screen order.

    obj_code_t  code_q;
    ysub_t      ysub_q;
    hpos_t      xpos_q;
    logic       hflip_q;
    logic       size_q;
    pal_t       pal_q;
    prio_t      prio_q;
    rom_word_t  row_q;

    logic       scr_half;       // screen column of the current half.
    logic [2:0] nib_sel;
    col_t       colour;

    assign rom_addr = {code_q, half_q, ysub_q};

    // with hflip the right half comes first, so it lands on the left of the sprite.
    assign scr_half = size_q & (half_q ^ hflip_q);
    // nibble 7 is the leftmost pixel; mirroring walks the row from nibble 0 up.
    assign nib_sel  = hflip_q ? cnt_q : ~cnt_q;
    assign colour   = row_q[{nib_sel, 2'b00} +: $bits(col_t)];

    assign wr_en   = emit_q && (colour != '0);         // transparent pixels are skipped.
    assign wr_addr = xpos_q + {5'd0, scr_half, cnt_q};  // wraps past 511 on its own.
    assign wr_pxl  = {prio_q, pal_q, colour};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rom_cs <= 1'b0;
            emit_q <= 1'b0;
            more_q <= 1'b0;
            half_q <= 1'b0;
            cnt_q  <= '0;
        end else if (draw && !busy) begin
            busy   <= 1'b1;
            rom_cs <= 1'b1;
            emit_q <= 1'b0;
            more_q <= size;             // 16x16 needs a second row fetch.
            half_q <= size & hflip;
            cnt_q  <= '0;
        end else if (rom_cs) begin
            // the address stays put until the ROM answers.
            if (rom_ok) begin
                rom_cs <= 1'b0;
                emit_q <= 1'b1;
                cnt_q  <= '0;
            end
        end else if (emit_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == 3'(ROW_PIX - 1)) begin
                emit_q <= 1'b0;
                if (more_q) begin
                    more_q <= 1'b0;
                    half_q <= ~half_q;
                    rom_cs <= 1'b1;
                end else begin
                    busy <= 1'b0;       // falls right after the last pixel slot.
                end
            end
        end
    end

    // request fields and the fetched row.
    always_ff @(posedge clk) begin
        if (draw && !busy) begin
            code_q  <= code;
            ysub_q  <= ysub;
            xpos_q  <= xpos;
            hflip_q <= hflip;
            size_q  <= size;
            pal_q   <= pal;
            prio_q  <= prio;
        end
        if (rom_cs && rom_ok) begin
            row_q <= rom_data;
        end
    end

endmodule

`default_nettype wire

// ==== obj/obj_linebuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_linebuf (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     hs,
    input  wire                     pxl_cen,
    input  wire obj_pkg::hpos_t     hdump,

    input  wire                     wr_en,
    input  wire obj_pkg::hpos_t     wr_addr,
    input  wire obj_pkg::obj_pxl_t  wr_pxl,

    output obj_pkg::obj_pxl_t       pxl
);
    import obj_pkg::*;

    obj_pxl_t mem [2][LB_DEPTH];   // two banks, one built while the other plays out.
    logic     bank_q;              // bank that is being written.
    logic     rd_bank;
    logic     free;                // target entry still holds a transparent pixel.

    assign rd_bank = ~bank_q;
    assign free    = mem[bank_q][wr_addr][$bits(col_t)-1:0] == '0;

    // the bank select flips on every line strobe.
    // a read in the same clock still uses the old bank.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_q <= 1'b0;
            pxl    <= '0;
        end else begin
            if (hs) begin
                bank_q <= ~bank_q;
            end
            if (pxl_cen) begin
                pxl <= mem[rd_bank][hdump];   // one clock behind hdump.
            end
        end
    end

    always_ff @(posedge clk) begin
        // sprites come in table order, so the first opaque write to an entry
        // belongs to the lowest index and later ones are dropped.
        if (wr_en && free) begin
            mem[bank_q][wr_addr] <= wr_pxl;
        end
        // played out entries are wiped so the bank is clean when it is written next.
        if (pxl_cen) begin
            mem[rd_bank][hdump] <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/obj_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_layer (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     pxl_cen,
    input  wire                     hs,
    input  wire                     lvbl,
    input  wire obj_pkg::hpos_t     hdump,
    input  wire obj_pkg::vpos_t     vrender,

    output obj_pkg::ram_addr_t      ram_addr,
    input  wire obj_pkg::ram_word_t ram_dout,

    output logic                    rom_cs,
    output obj_pkg::rom_addr_t      rom_addr,
    input  wire obj_pkg::rom_word_t rom_data,
    input  wire                     rom_ok,

    output obj_pkg::obj_pxl_t       pxl
);
    import obj_pkg::*;

    // scan to draw request.
    logic       dr_draw;
    logic       dr_busy;
    obj_code_t  dr_code;
    ysub_t      dr_ysub;
    hpos_t      dr_xpos;
    logic       dr_hflip;
    logic       dr_size;
    pal_t       dr_pal;
    prio_t      dr_prio;

    // draw to line buffer writes.
    logic       lb_wr_en;
    hpos_t      lb_wr_addr;
    obj_pxl_t   lb_wr_pxl;

    obj_scan u_scan (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .hs         ( hs         ),
        .lvbl       ( lvbl       ),
        .vrender    ( vrender    ),
        .ram_addr   ( ram_addr   ),
        .ram_dout   ( ram_dout   ),
        .draw       ( dr_draw    ),
        .busy       ( dr_busy    ),
        .code       ( dr_code    ),
        .ysub       ( dr_ysub    ),
        .xpos       ( dr_xpos    ),
        .hflip      ( dr_hflip   ),
        .size       ( dr_size    ),
        .pal        ( dr_pal     ),
        .prio       ( dr_prio    )
    );

    obj_draw u_draw (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .draw       ( dr_draw    ),
        .busy       ( dr_busy    ),
        .code       ( dr_code    ),
        .ysub       ( dr_ysub    ),
        .xpos       ( dr_xpos    ),
        .hflip      ( dr_hflip   ),
        .size       ( dr_size    ),
        .pal        ( dr_pal     ),
        .prio       ( dr_prio    ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .rom_ok     ( rom_ok     ),
        .rom_data   ( rom_data   ),
        .wr_en      ( lb_wr_en   ),
        .wr_addr    ( lb_wr_addr ),
        .wr_pxl     ( lb_wr_pxl  )
    );

    // the registered buffer output is the only delay on the pixel path.
    obj_linebuf u_linebuf (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .hs         ( hs         ),
        .pxl_cen    ( pxl_cen    ),
        .hdump      ( hdump      ),
        .wr_en      ( lb_wr_en   ),
        .wr_addr    ( lb_wr_addr ),
        .wr_pxl     ( lb_wr_pxl  ),
        .pxl        ( pxl        )
    );

endmodule

`default_nettype wire

// ==== test/obj_layer_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_layer_assert (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    draw,
    input wire                    busy,
    input wire                    rom_cs,
    input wire                    rom_ok,
    input wire obj_pkg::rom_addr_t rom_addr,
    input wire obj_pkg::obj_pxl_t  pxl
);

    int fail_cnt = 0;   // number of failed assertion attempts.

    // a pending ROM request keeps its address.
    rom_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> $stable(rom_addr))
        else begin
            $error("rom_addr moved while the request was pending");
            fail_cnt++;
        end

    draw_idle: assert property (@(posedge clk) disable iff (!rst_n)
        draw |-> !busy)
        else begin
            $error("draw strobe while busy");   // scan must wait for the engine.
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !draw && !rom_cs && pxl == '0)
        else begin
            $error("outputs active during reset");
            fail_cnt++;
        end

endmodule

bind obj_layer obj_layer_assert u_assert (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .draw     ( dr_draw  ),
    .busy     ( dr_busy  ),
    .rom_cs   ( rom_cs   ),
    .rom_ok   ( rom_ok   ),
    .rom_addr ( rom_addr ),
    .pxl      ( pxl      )
);

`default_nettype wire

// ==== test/obj_tb_tasks.svh ====
`ifndef OBJ_TB_TASKS_SVH
`define OBJ_TB_TASKS_SVH
`default_nettype none

// galois shift with taps for x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
endfunction

// the LFSR steps once for every bit that is taken.
task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
        v    = {v[30:0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
    end
endtask

// pattern data depends on every address bit; some nibbles are forced clear.
function automatic rom_word_t rom_pattern(input rom_addr_t a);
    rom_word_t  w;
    logic [3:0] nib;
    for (int n = 0; n < 8; n++) begin
        nib = 4'((a ^ (a >> 4) ^ (a >> 8) ^ (a >> 12) ^ (a >> 16)) + n * 5);
        if ((a + n) % 5 == 0) begin
            nib = 4'd0;                 // transparent pixel.
        end
        w[4*n +: 4] = nib;
    end
    return w;
endfunction

// expected pixel of display line v from the entry layout rules.
function automatic obj_pxl_t ref_pixel(input int v, input int h);
    ram_word_t w0, w1, w2, w3;
    int        t, hgt, diff, row, dx, c;
    rom_word_t word;
    logic [3:0] col;
    if (v == 1 || v == 2) begin
        return '0;                      // built during a blank line.
    end
    t = (v == 0) ? 16 : v;              // line 0 is prepared during line 15.
    for (int i = 0; i < NUM_OBJ; i++) begin
        w0   = tbl[i*4];
        w1   = tbl[i*4+1];
        w2   = tbl[i*4+2];
        w3   = tbl[i*4+3];
        hgt  = w0[8] ? 16 : 8;
        diff = (t - int'(w0[7:0])) & 255;
        dx   = (h - int'(w2[8:0])) & 511;
        if (w0[15] && diff < hgt && dx < hgt) begin
            row  = w1[15] ? hgt - 1 - diff : diff;
            c    = w1[14] ? hgt - 1 - dx : dx;
            word = rom_pattern({w1[11:0], 1'(c / 8), 4'(row)});
            col  = word[(7 - c % 8) * 4 +: 4];
            if (col != 4'd0) begin
                return {w3[5:4], w3[3:0], col};   // lowest opaque index wins.
            end
        end
    end
    return '0;
endfunction

task automatic check_pxl(input int h, input obj_pxl_t exp, input obj_pxl_t act);
    num_checks++;
    if (act !== exp) begin
        $display("ERR pxl hdump=%h exp=%h act=%h", h, exp, act);
        num_errors++;
    end
endtask

task automatic clear_table();
    for (int i = 0; i < 256; i++) begin
        tbl[i] = '0;
    end
endtask

task automatic set_entry(input int idx, input logic en, input logic size, input logic [7:0] y,
                         input logic [11:0] code, input logic hf, input logic vf,
                         input logic [8:0] x, input logic [3:0] pal, input logic [1:0] prio);
    tbl[idx*4]   = {en, 6'd0, size, y};
    tbl[idx*4+1] = {vf, hf, 2'b00, code};
    tbl[idx*4+2] = {7'd0, x};
    tbl[idx*4+3] = {10'd0, prio, pal};
endtask

// two frames flush the old table and the third one is compared.
task automatic compare_frame();
    int k;
    k = frame_cnt;
    wait (frame_cnt != k);
    k = frame_cnt;
    wait (frame_cnt != k);
    checking = 1'b1;
    k = frame_cnt;
    wait (frame_cnt != k);
    @(posedge clk);                     // the last pixel of the frame is compared by now.
    checking = 1'b0;
endtask

task automatic empty_table();
    clear_table();
    compare_frame();
endtask

task automatic single_sprite();
    clear_table();
    set_entry(5, 1'b1, 1'b1, 8'd3, 12'h123, 1'b0, 1'b0, 9'd100, 4'h6, 2'd2);
    compare_frame();
endtask

task automatic flipped_sprites();
    clear_table();
    set_entry(0, 1'b1, 1'b1, 8'd4, 12'h0a5, 1'b1, 1'b1, 9'd20, 4'h3, 2'd1);
    set_entry(1, 1'b1, 1'b0, 8'd6, 12'h311, 1'b1, 1'b0, 9'd200, 4'h9, 2'd3);
    set_entry(2, 1'b1, 1'b1, 8'd2, 12'h7c2, 1'b0, 1'b1, 9'd506, 4'hc, 2'd0);  // wraps to 0.
    compare_frame();
endtask

task automatic sprite_overlap();
    clear_table();
    set_entry(3, 1'b1, 1'b1, 8'd5, 12'h007, 1'b0, 1'b0, 9'd60, 4'h1, 2'd1);
    set_entry(9, 1'b1, 1'b1, 8'd8, 12'h008, 1'b0, 1'b0, 9'd66, 4'h2, 2'd3);
    compare_frame();
endtask

task automatic rom_latency();
    rand_lat = 1'b1;
    clear_table();
    set_entry(0, 1'b0, 1'b1, 8'd3, 12'h555, 1'b0, 1'b0, 9'd100, 4'hf, 2'd3);  // disabled.
    set_entry(5, 1'b1, 1'b1, 8'd3, 12'h123, 1'b0, 1'b0, 9'd100, 4'h6, 2'd2);
    set_entry(7, 1'b1, 1'b0, 8'd251, 12'h444, 1'b0, 1'b0, 9'd30, 4'h4, 2'd1);
    set_entry(8, 1'b1, 1'b1, 8'd200, 12'h666, 1'b0, 1'b0, 9'd150, 4'h5, 2'd0);
    compare_frame();
    rand_lat = 1'b0;
endtask

`default_nettype wire
`endif

// ==== test/obj_layer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module obj_layer_tb;
    import obj_pkg::*;

    localparam int TEST_FRAMES = 15;                        // at most three frames per test.
    localparam int LIMIT = TEST_FRAMES * 16 * 768 * 11 / 10;
    localparam int EXP_CHECKS = 5 * 16 * 384;               // five checked frames.

    logic      clk;
    logic      rst_n;
    logic      pxl_cen;
    logic      hs;
    logic      lvbl;
    hpos_t     hdump;
    vpos_t     vrender;
    ram_addr_t ram_addr;
    ram_word_t ram_dout;
    logic      rom_cs;
    rom_addr_t rom_addr;
    rom_word_t rom_data;
    logic      rom_ok;
    obj_pxl_t  pxl;

    ram_word_t   tbl [256];          // sprite attribute RAM contents.
    int          cc = 0;             // clock within the line at two clocks per pixel.
    int          line = 0;
    int          frame_cnt = 0;
    int          cycles = 0;
    int          num_checks = 0;
    int          num_errors = 0;
    int          rom_pend = 0;       // clocks left before the ROM answers.
    logic        rand_lat = 1'b0;    // random ROM latency when set.
    logic        checking = 1'b0;
    logic [31:0] lfsr;
    logic [31:0] rbits;
    logic        cen_d = 1'b0;       // registered copies of what the last edge saw.
    logic        chk_d = 1'b0;
    int          h_d;
    int          v_d;
    ram_addr_t   ram_q = '0;

    obj_layer u_dut (.*);

    `include "obj_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // video timing is driven on the falling edge for the next rising edge.
    always @(negedge clk) begin
        hs      = cc == 0;
        pxl_cen = cc[0];                    // pixel 0 is read on the clock after hs.
        hdump   = hpos_t'(cc / 2);
        vrender = vpos_t'(line);
        lvbl    = line >= 2;                // lines 0 and 1 are blanking.
        if (cc == 0 && line == 0) begin
            frame_cnt++;
        end
        cc++;
        if (cc == 768) begin
            cc   = 0;
            line = (line + 1) % 16;
        end
    end

    // the RAM registers its address, so data trails by one clock.
    always @(negedge clk) begin
        ram_dout = tbl[ram_q];
    end

    // ROM model with a delay of 1 to 4 clocks.
    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok = 1'b0;                  // the answer lasted one clock.
        end else if (rom_cs) begin
            if (rom_pend == 0) begin
                if (rand_lat) begin
                    take_bits(2, rbits);
                    rom_pend = rbits + 1;
                end else begin
                    rom_pend = 1;
                end
            end
            rom_pend--;
            if (rom_pend == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_pattern(rom_addr);
            end
        end
    end

    always @(posedge clk) begin
        cen_d <= pxl_cen;
        chk_d <= checking;
        h_d   <= hdump;
        v_d   <= vrender;
        ram_q <= ram_addr;
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the tests did not finish within %0d clocks", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    // pxl is compared half a clock after the register that follows each pxl_cen.
    always @(negedge clk) begin
        if (chk_d && cen_d) begin
            check_pxl(h_d, ref_pixel(v_d, h_d), pxl);
        end
    end

    initial begin
        pxl_cen  = 1'b0;
        hs       = 1'b0;
        lvbl     = 1'b0;
        hdump    = '0;
        vrender  = '0;
        ram_dout = '0;
        rom_data = '0;
        rom_ok   = 1'b0;
        lfsr     = 32'h3812b15f;
        rst_n    = 1'b0;
        clear_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        empty_table();
        single_sprite();
        flipped_sprites();
        sprite_overlap();
        rom_latency();
        if (num_checks != EXP_CHECKS) begin
            $display("only %0d of %0d pixels were compared", num_checks, EXP_CHECKS);
            num_errors++;
        end
        if (u_dut.u_assert.fail_cnt != 0) begin
            $display("%0d assertion checks failed", u_dut.u_assert.fail_cnt);
            num_errors += u_dut.u_assert.fail_cnt;
        end
        $display("checks %0d errors %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+test
common/obj_pkg.sv
obj/obj_scan.sv
obj/obj_draw.sv
obj/obj_linebuf.sv
verilog/obj_layer.sv
test/obj_layer_assert.sv
test/obj_layer_tb.sv
